// ==== fix_pkg.sv ====
// FIX rx package: sizes, characters, tag numbers, error and type codes, field and result structs
package fix_pkg;

	localparam int VAL_W = 32;		// numeric value width
	localparam int TEXT_CHARS = 4;		// trailing value chars kept
	localparam int SUPPORTED_VERSION = 44;	// FIX.4.4 and below

	localparam logic [7:0] CHAR_SOH = 8'h01;
	localparam logic [7:0] CHAR_EQ = 8'h3D;
	localparam logic [7:0] CHAR_Y = 8'h59;

	localparam logic [7:0] SOM_TAG_BYTES = 8'h75;	// "8=" already seen at som strobe
	localparam logic [7:0] CK_TAG_BYTES = 8'h9E;	// "10=" swept into the sum

	// header tags, in the order they must arrive
	localparam logic [31:0] TAG_BEGIN_STRING = 32'd8;
	localparam logic [31:0] TAG_BODY_LENGTH = 32'd9;
	localparam logic [31:0] TAG_MSG_SEQ_NUM = 32'd34;
	localparam logic [31:0] TAG_MSG_TYPE = 32'd35;
	localparam logic [31:0] TAG_POSS_DUP = 32'd43;
	localparam logic [31:0] TAG_SENDER_COMP = 32'd49;
	localparam logic [31:0] TAG_TARGET_COMP = 32'd56;
	localparam logic [31:0] TAG_SENDING_TIME = 32'd52;
	localparam logic [31:0] TAG_GAP_FILL = 32'd123;
	localparam logic [31:0] TAG_NEW_SEQ_NO = 32'd36;
	localparam logic [31:0] TAG_CHECKSUM = 32'd10;

	typedef enum logic [3:0] {
		ERR_NONE = 4'd0,
		ERR_GARBLED = 4'd1,
		ERR_VERSION = 4'd2,
		ERR_MSG_TYPE = 4'd3,
		ERR_TAG_MISSING = 4'd4,
		ERR_SEQ_LOW = 4'd5,
		ERR_SEQ_HIGH = 4'd6
	} fix_err_e;

	typedef enum logic [3:0] {
		TYPE_OTHER = 4'd0,
		TYPE_LOGON = 4'd1,	// "A"
		TYPE_HEARTBEAT = 4'd2,	// "0"
		TYPE_LOGOUT = 4'd3,	// "5"
		TYPE_RESET = 4'd4,	// "4" without gap fill
		TYPE_GAP_FILL = 4'd5	// "4" with gap fill Y
	} fix_type_e;

	typedef struct packed {
		logic tag_valid;
		logic val_valid;
		logic som;		// first tag of a message
		logic eom;		// tag 10
		logic [31:0] tag;
		logic [VAL_W-1:0] num;	// digits only, decimal
		logic [8*TEXT_CHARS-1:0] text;	// newest char in low byte
		logic [3:0] len;	// saturates at 15
	} fix_field_t;

	typedef struct packed {
		fix_err_e err;
		fix_type_e mtype;
		logic [VAL_W-1:0] seq_num;
		logic [VAL_W-1:0] new_seq_num;
	} fix_result_t;

endpackage

// ==== fix_tag_parser.sv ====
// FIX byte parser: tag/value split on '=' and SOH, numeric, text and length forms of each value
`timescale 1ns/1ps

module fix_tag_parser (
	input logic clk,
	input logic rst,
	input logic byte_valid_i,
	input logic [7:0] byte_i,
	output fix_pkg::fix_field_t field_o
);

	localparam int TW = 8 * fix_pkg::TEXT_CHARS;

	logic in_value;		// 0 while reading the tag number
	logic som_pend;		// next tag opens a message
	logic ck_field;		// current value belongs to tag 10
	logic [31:0] tag_acc;
	logic [fix_pkg::VAL_W-1:0] num_acc;
	logic [TW-1:0] text_acc;
	logic [3:0] len_acc;

	logic tag_stb, val_stb, som_q, eom_q;
	logic [31:0] tag_q;
	logic [fix_pkg::VAL_W-1:0] num_q;
	logic [TW-1:0] text_q;
	logic [3:0] len_q;

	logic is_digit, eq_hit, soh_hit, tag_is_ck;

	assign is_digit = (byte_i >= 8'h30) && (byte_i <= 8'h39);
	assign eq_hit = byte_valid_i && !in_value && (byte_i == fix_pkg::CHAR_EQ);	// '=' inside a value is data
	assign soh_hit = byte_valid_i && (byte_i == fix_pkg::CHAR_SOH);
	assign tag_is_ck = (tag_acc == fix_pkg::TAG_CHECKSUM);

	always_ff @(posedge clk) begin
		if (rst) begin
			in_value <= 1'b0;
			som_pend <= 1'b1;
			ck_field <= 1'b0;
			tag_stb <= 1'b0;
			val_stb <= 1'b0;
			som_q <= 1'b0;
			eom_q <= 1'b0;
			tag_acc <= '0;
			num_acc <= '0;
			text_acc <= '0;
			len_acc <= '0;
		end else begin
			tag_stb <= eq_hit;
			val_stb <= soh_hit && in_value;
			som_q <= eq_hit && som_pend;
			eom_q <= eq_hit && tag_is_ck;
			if (eq_hit) begin
				in_value <= 1'b1;
				som_pend <= 1'b0;
				ck_field <= tag_is_ck;
				tag_acc <= '0;
				num_acc <= '0;
				text_acc <= '0;
				len_acc <= '0;
			end else if (soh_hit) begin
				in_value <= 1'b0;
				if (in_value && ck_field)
					som_pend <= 1'b1;	// checksum value closes the message
				tag_acc <= '0;			// also drops junk before a stray SOH
			end else if (byte_valid_i) begin
				if (!in_value) begin
					if (is_digit)
						tag_acc <= tag_acc * 32'd10 + 32'(byte_i[3:0]);
				end else begin
					if (is_digit)
						num_acc <= num_acc * fix_pkg::VAL_W'(10) + fix_pkg::VAL_W'(byte_i[3:0]);
					text_acc <= {text_acc[TW-9:0], byte_i};
					if (len_acc != 4'hF)
						len_acc <= len_acc + 4'd1;
				end
			end
		end
	end

	// field payload, held until the next strobe
	always_ff @(posedge clk) begin
		if (eq_hit)
			tag_q <= tag_acc;
		if (soh_hit) begin
			num_q <= num_acc;
			text_q <= text_acc;
			len_q <= len_acc;
		end
	end

	assign field_o = '{tag_valid: tag_stb, val_valid: val_stb, som: som_q, eom: eom_q,
		tag: tag_q, num: num_q, text: text_q, len: len_q};

endmodule

// ==== fix_checksum.sv ====
// FIX checksum unit: running byte sum per message, compared with the tag 10 value
`timescale 1ns/1ps

module fix_checksum (
	input logic clk,
	input logic rst,
	input logic byte_valid_i,
	input logic [7:0] byte_i,
	input fix_pkg::fix_field_t field_i,
	output logic ck_valid_o,
	output logic ck_ok_o
);

	logic [7:0] sum_q;
	logic [7:0] frozen_q;	// sum up to the SOH before "10="
	logic [7:0] byte_add;
	logic in_ck;

	assign byte_add = byte_valid_i ? byte_i : 8'h00;

	always_ff @(posedge clk) begin
		if (field_i.tag_valid && field_i.som)
			sum_q <= fix_pkg::SOM_TAG_BYTES + byte_add;	// restart, "8=" is behind us
		else
			sum_q <= sum_q + byte_add;
		if (field_i.tag_valid && field_i.eom)
			frozen_q <= sum_q - fix_pkg::CK_TAG_BYTES;
		ck_ok_o <= (field_i.num == fix_pkg::VAL_W'(frozen_q));
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			in_ck <= 1'b0;
			ck_valid_o <= 1'b0;
		end else begin
			ck_valid_o <= field_i.val_valid && in_ck;
			if (field_i.tag_valid)
				in_ck <= field_i.eom;
			else if (field_i.val_valid)
				in_ck <= 1'b0;
		end
	end

endmodule

// ==== fix_msg_processor.sv ====
// FIX message processor: header order FSM, body field capture, final verdict and message type
`timescale 1ns/1ps

module fix_msg_processor (
	input logic clk,
	input logic rst,
	input fix_pkg::fix_field_t field_i,
	input logic ck_valid_i,
	input logic ck_ok_i,
	input logic [fix_pkg::VAL_W-1:0] expected_seq_i,
	output logic msg_done_o,
	output fix_pkg::fix_result_t result_o
);

	typedef enum logic [3:0] {
		S_IDLE, S_BEGIN_VAL, S_BLEN_TAG, S_BLEN_VAL, S_SEQ_TAG, S_SEQ_VAL,
		S_TYPE_TAG, S_TYPE_VAL, S_BODY_TAG, S_BODY_VAL, S_WAIT
	} state_e;

	typedef struct packed {
		logic poss_dup_y;
		logic gap_fill_y;
		logic has_sender;
		logic has_target;
		logic has_time;
		logic [fix_pkg::VAL_W-1:0] new_seq;	// 0 when tag 36 is absent
	} body_t;

	state_e state;
	body_t body;
	logic [31:0] cur_tag;
	logic [fix_pkg::VAL_W-1:0] seq_q;
	logic [7:0] type_char;
	logic type_one;		// single char MsgType
	fix_pkg::fix_err_e hdr_err, fin_err;
	logic reset_only, seq_low;

	function automatic fix_pkg::fix_type_e decode_type(input logic [7:0] c, input logic one,
			input logic gap);
		fix_pkg::fix_type_e t;
		t = fix_pkg::TYPE_OTHER;
		if (one) begin
			case (c)
			"A": t = fix_pkg::TYPE_LOGON;
			"0": t = fix_pkg::TYPE_HEARTBEAT;
			"5": t = fix_pkg::TYPE_LOGOUT;
			"4": t = gap ? fix_pkg::TYPE_GAP_FILL : fix_pkg::TYPE_RESET;
			default: t = fix_pkg::TYPE_OTHER;
			endcase
		end
		return t;
	endfunction

	// header faults, judged on the strobe itself
	always_comb begin
		hdr_err = fix_pkg::ERR_NONE;
		case (state)
		S_IDLE: if (field_i.tag_valid && field_i.som && field_i.tag != fix_pkg::TAG_BEGIN_STRING)
			hdr_err = fix_pkg::ERR_GARBLED;
		S_BEGIN_VAL: if (field_i.val_valid && field_i.num > fix_pkg::SUPPORTED_VERSION)
			hdr_err = fix_pkg::ERR_VERSION;
		S_BLEN_TAG: if (field_i.tag_valid && field_i.tag != fix_pkg::TAG_BODY_LENGTH)
			hdr_err = fix_pkg::ERR_GARBLED;
		S_SEQ_TAG: if (field_i.tag_valid && field_i.tag != fix_pkg::TAG_MSG_SEQ_NUM)
			hdr_err = fix_pkg::ERR_GARBLED;
		S_TYPE_TAG: if (field_i.tag_valid && field_i.tag != fix_pkg::TAG_MSG_TYPE)
			hdr_err = fix_pkg::ERR_GARBLED;
		S_TYPE_VAL: if (field_i.val_valid && field_i.len > 4'd2)
			hdr_err = fix_pkg::ERR_MSG_TYPE;
		default: hdr_err = fix_pkg::ERR_NONE;
		endcase
	end

	assign reset_only = type_one && (type_char == "4") && !body.gap_fill_y;
	assign seq_low = (seq_q < expected_seq_i) && !body.poss_dup_y && !reset_only;

	// verdict priority at checksum time
	always_comb begin
		if (seq_low)
			fin_err = fix_pkg::ERR_SEQ_LOW;
		else if (!ck_ok_i)
			fin_err = fix_pkg::ERR_GARBLED;
		else if (!(body.has_sender && body.has_target && body.has_time))
			fin_err = fix_pkg::ERR_TAG_MISSING;
		else if (seq_q > expected_seq_i)
			fin_err = fix_pkg::ERR_SEQ_HIGH;
		else
			fin_err = fix_pkg::ERR_NONE;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			msg_done_o <= 1'b0;
		end else begin
			msg_done_o <= 1'b0;
			if (hdr_err != fix_pkg::ERR_NONE) begin
				msg_done_o <= 1'b1;
				result_o <= '{err: hdr_err, mtype: fix_pkg::TYPE_OTHER, seq_num: '0, new_seq_num: '0};
				state <= S_IDLE;	// drop the rest until the next som
			end else begin
				case (state)
				S_IDLE: if (field_i.tag_valid && field_i.som) begin
					body <= '0;
					state <= S_BEGIN_VAL;
				end
				S_BEGIN_VAL: if (field_i.val_valid) state <= S_BLEN_TAG;
				S_BLEN_TAG: if (field_i.tag_valid) state <= S_BLEN_VAL;
				S_BLEN_VAL: if (field_i.val_valid) state <= S_SEQ_TAG;	// length not checked
				S_SEQ_TAG: if (field_i.tag_valid) state <= S_SEQ_VAL;
				S_SEQ_VAL: if (field_i.val_valid) begin
					seq_q <= field_i.num;
					state <= S_TYPE_TAG;
				end
				S_TYPE_TAG: if (field_i.tag_valid) state <= S_TYPE_VAL;
				S_TYPE_VAL: if (field_i.val_valid) begin
					type_char <= field_i.text[7:0];
					type_one <= (field_i.len == 4'd1);
					state <= S_BODY_TAG;
				end
				S_BODY_TAG: if (field_i.tag_valid) begin
					cur_tag <= field_i.tag;
					state <= field_i.eom ? S_WAIT : S_BODY_VAL;
				end
				S_BODY_VAL: if (field_i.val_valid) begin
					case (cur_tag)
					fix_pkg::TAG_POSS_DUP: body.poss_dup_y <= (field_i.text[7:0] == fix_pkg::CHAR_Y);
					fix_pkg::TAG_GAP_FILL: body.gap_fill_y <= (field_i.text[7:0] == fix_pkg::CHAR_Y);
					fix_pkg::TAG_SENDER_COMP: body.has_sender <= 1'b1;
					fix_pkg::TAG_TARGET_COMP: body.has_target <= 1'b1;
					fix_pkg::TAG_SENDING_TIME: body.has_time <= 1'b1;
					fix_pkg::TAG_NEW_SEQ_NO: body.new_seq <= field_i.num;
					default: ;	// unknown tags pass
					endcase
					state <= S_BODY_TAG;
				end
				S_WAIT: if (ck_valid_i) begin
					msg_done_o <= 1'b1;
					result_o <= '{err: fin_err,
						mtype: decode_type(type_char, type_one, body.gap_fill_y),
						seq_num: seq_q, new_seq_num: body.new_seq};
					state <= S_IDLE;
				end
				default: state <= S_IDLE;
				endcase
			end
		end
	end

endmodule

// ==== fix_seq_tracker.sv ====
// FIX sequence tracker: next expected incoming MsgSeqNum, updated from each verdict
`timescale 1ns/1ps

module fix_seq_tracker (
	input logic clk,
	input logic rst,
	input logic msg_done_i,
	input fix_pkg::fix_result_t result_i,
	output logic [fix_pkg::VAL_W-1:0] expected_seq_o
);

	logic hold;		// verdicts that never move the counter
	logic is_reset;

	assign hold = (result_i.err == fix_pkg::ERR_SEQ_HIGH) ||
		(result_i.err == fix_pkg::ERR_GARBLED) ||
		(result_i.err == fix_pkg::ERR_VERSION) ||
		(result_i.err == fix_pkg::ERR_MSG_TYPE);

	assign is_reset = (result_i.mtype == fix_pkg::TYPE_RESET) ||
		(result_i.mtype == fix_pkg::TYPE_GAP_FILL);

	always_ff @(posedge clk) begin
		if (rst) begin
			expected_seq_o <= fix_pkg::VAL_W'(1);
		end else if (msg_done_i && !hold) begin
			// reset/gap fill may only move forward
			if (is_reset && (result_i.new_seq_num > result_i.seq_num))
				expected_seq_o <= result_i.new_seq_num;
			else if (result_i.err == fix_pkg::ERR_NONE)
				expected_seq_o <= result_i.seq_num + fix_pkg::VAL_W'(1);
		end
	end

endmodule

// ==== fix_rx_top.sv ====
// FIX receive top: parser, checksum, message processor and sequence tracker
`timescale 1ns/1ps

module fix_rx_top (
	input logic clk,
	input logic rst,
	input logic byte_valid_i,
	input logic [7:0] byte_i,
	output logic msg_done_o,
	output fix_pkg::fix_result_t result_o
);

	fix_pkg::fix_field_t field;
	logic ck_valid, ck_ok;
	logic [fix_pkg::VAL_W-1:0] expected_seq;

	fix_tag_parser u_parser (
		.clk(clk), .rst(rst),
		.byte_valid_i(byte_valid_i), .byte_i(byte_i),
		.field_o(field)
	);

	fix_checksum u_checksum (
		.clk(clk), .rst(rst),
		.byte_valid_i(byte_valid_i), .byte_i(byte_i),	// sums the raw stream
		.field_i(field),
		.ck_valid_o(ck_valid), .ck_ok_o(ck_ok)
	);

	fix_msg_processor u_processor (
		.clk(clk), .rst(rst),
		.field_i(field),
		.ck_valid_i(ck_valid), .ck_ok_i(ck_ok),
		.expected_seq_i(expected_seq),
		.msg_done_o(msg_done_o), .result_o(result_o)
	);

	fix_seq_tracker u_seq (
		.clk(clk), .rst(rst),
		.msg_done_i(msg_done_o), .result_i(result_o),
		.expected_seq_o(expected_seq)
	);

endmodule

// ==== fix_rx_props.sv ====
// FIX processor assertions: strobe exclusion, single-cycle done, done low around reset
`timescale 1ns/1ps

module fix_rx_props (
	input logic clk,
	input logic rst,
	input fix_pkg::fix_field_t field_i,
	input logic msg_done_i
);

	int fail_count = 0;	// failures seen so far

	a_strobe_excl: assert property (@(posedge clk) disable iff (rst)
		!(field_i.tag_valid && field_i.val_valid))
		else begin
			fail_count++;
			$error("tag and value strobes high in the same cycle");
		end

	a_done_pulse: assert property (@(posedge clk) disable iff (rst)
		msg_done_i |=> !msg_done_i)
		else begin
			fail_count++;
			$error("msg_done held longer than one cycle");
		end

	// covers the reset cycles and the first one after release
	a_done_reset: assert property (@(posedge clk) rst |=> !msg_done_i)
		else begin
			fail_count++;
			$error("msg_done high during or right after reset");
		end

endmodule

bind fix_msg_processor fix_rx_props u_props (
	.clk(clk), .rst(rst), .field_i(field_i), .msg_done_i(msg_done_o)
);

// ==== tb_fix_rx.sv ====
// FIX rx testbench: LFSR, message builder, reference model, verdict check and report
`timescale 1ns/1ps

module tb_fix_rx;

	logic clk = 1'b0;
	logic rst;
	logic byte_valid_i;
	logic [7:0] byte_i;
	logic msg_done_o;
	fix_pkg::fix_result_t result_o;

	logic [31:0] lfsr_q = 32'h816a_686f;
	logic [7:0] msg_q[$];			// bytes of the message being sent
	fix_pkg::fix_result_t exp_q[$];		// verdicts the DUT still owes
	int unsigned model_exp = 1;		// model copy of the expected seq
	int n_checks = 0;
	int n_errors = 0;
	int n_tests = 0;
	int test_err0 = 0;
	string test_name = "reset";
	string types[5] = '{"A", "0", "5", "4", "D"};

	fix_rx_top UUT (
		.clk(clk), .rst(rst),
		.byte_valid_i(byte_valid_i), .byte_i(byte_i),
		.msg_done_o(msg_done_o), .result_o(result_o)
	);

	always #5 clk = ~clk;

	// x^32 + x^22 + x^2 + x + 1, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
			lfsr_q = {lfsr_q[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	task automatic check_value(input string what, input logic [71:0] exp, input logic [71:0] act);
		n_checks++;
		if (exp !== act) begin
			n_errors++;
			$display("error %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic put_field(input int tag, input string val);
		string s;
		s = $sformatf("%0d=%s", tag, val);
		for (int i = 0; i < s.len(); i++)
			msg_q.push_back(s[i]);
		msg_q.push_back(8'h01);		// SOH
	endtask

	// kind: 0 good, 1 bad checksum, 2 tag order, 3 version, 4 long type, 5 dropped tag
	task automatic build_msg(input int kind, input string mt, input int unsigned seq,
			input bit poss_dup, input bit gap_fill, input int unsigned new_seq);
		fix_pkg::fix_result_t r;
		logic [7:0] ck;
		logic [7:0] ck_sent;
		int drop;
		bit reset_only;
		msg_q.delete();
		drop = (kind == 5) ? 1 + rand_bits(5) % 3 : 0;
		put_field(8, (kind == 3) ? "FIX.4.5" : "FIX.4.4");
		put_field(9, $sformatf("%0d", 40 + rand_bits(6)));	// length is never checked
		if (kind == 2)
			put_field(35, mt);
		put_field(34, $sformatf("%0d", seq));
		if (kind != 2)
			put_field(35, (kind == 4) ? "AB1" : mt);
		if (poss_dup)
			put_field(43, "Y");
		if (drop != 1)
			put_field(49, "BUYSIDE");
		if (drop != 2)
			put_field(56, "SELLSIDE");
		if (drop != 3)
			put_field(52, $sformatf("%0d", rand_bits(20)));
		if (new_seq != 0)
			put_field(36, $sformatf("%0d", new_seq));
		if (gap_fill)
			put_field(123, "Y");
		ck = 8'h00;
		foreach (msg_q[i])
			ck = ck + msg_q[i];
		ck_sent = (kind == 1) ? ck + 8'd1 + 8'(rand_bits(8) % 255) : ck;
		put_field(10, $sformatf("%03d", ck_sent));

		// expected verdict from the header and session rules
		r = '{err: fix_pkg::ERR_NONE, mtype: fix_pkg::TYPE_OTHER, seq_num: '0, new_seq_num: '0};
		if (kind == 3)
			r.err = fix_pkg::ERR_VERSION;
		else if (kind == 2)
			r.err = fix_pkg::ERR_GARBLED;
		else if (kind == 4)
			r.err = fix_pkg::ERR_MSG_TYPE;
		else begin
			r.seq_num = seq;
			r.new_seq_num = new_seq;
			if (mt == "A")
				r.mtype = fix_pkg::TYPE_LOGON;
			else if (mt == "0")
				r.mtype = fix_pkg::TYPE_HEARTBEAT;
			else if (mt == "5")
				r.mtype = fix_pkg::TYPE_LOGOUT;
			else if (mt == "4")
				r.mtype = gap_fill ? fix_pkg::TYPE_GAP_FILL : fix_pkg::TYPE_RESET;
			reset_only = (mt == "4") && !gap_fill;
			if (seq < model_exp && !poss_dup && !reset_only)
				r.err = fix_pkg::ERR_SEQ_LOW;
			else if (kind == 1)
				r.err = fix_pkg::ERR_GARBLED;
			else if (drop != 0)
				r.err = fix_pkg::ERR_TAG_MISSING;
			else if (seq > model_exp)
				r.err = fix_pkg::ERR_SEQ_HIGH;
		end
		if (!(r.err inside {fix_pkg::ERR_SEQ_HIGH, fix_pkg::ERR_GARBLED,
				fix_pkg::ERR_VERSION, fix_pkg::ERR_MSG_TYPE})) begin
			if ((r.mtype inside {fix_pkg::TYPE_RESET, fix_pkg::TYPE_GAP_FILL}) && new_seq > seq)
				model_exp = new_seq;
			else if (r.err == fix_pkg::ERR_NONE)
				model_exp = seq + 1;
		end
		exp_q.push_back(r);
	endtask

	// leaves the last byte valid, so the next message may follow at once
	task automatic send_msg();
		int gap;
		foreach (msg_q[i]) begin
			gap = (rand_bits(2) == 0) ? rand_bits(2) : 0;
			repeat (gap) begin
				@(posedge clk);
				byte_valid_i <= 1'b0;
			end
			@(posedge clk);
			byte_valid_i <= 1'b1;
			byte_i <= msg_q[i];
		end
	endtask

	task automatic wait_verdicts();
		int t;
		t = 0;
		@(posedge clk);
		byte_valid_i <= 1'b0;
		while (exp_q.size() != 0 && t < 100) begin
			@(posedge clk);
			t++;
		end
		if (exp_q.size() != 0) begin
			n_errors++;
			$display("%s: timed out waiting for %0d verdicts", test_name, exp_q.size());
			exp_q.delete();
		end
	endtask

	task automatic run_one(input int kind, input string mt, input int unsigned seq,
			input bit poss_dup, input bit gap_fill, input int unsigned new_seq);
		build_msg(kind, mt, seq, poss_dup, gap_fill, new_seq);
		send_msg();
		wait_verdicts();
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_err0 = n_errors;
	endtask

	task automatic end_test();
		n_tests++;
		$display("test %s finished with %0d errors", test_name, n_errors - test_err0);
	endtask

	always @(posedge clk) begin
		if (!rst && msg_done_o) begin
			if (exp_q.size() == 0) begin
				n_errors++;
				$display("%s: verdict arrived with no message outstanding", test_name);
			end else
				check_value("verdict", exp_q.pop_front(), result_o);
		end
	end

	initial begin
		int kind;
		int unsigned seq;
		string mt;
		rst = 1'b1;
		byte_valid_i = 1'b0;
		byte_i = 8'h00;
		repeat (10) @(posedge clk);
		rst <= 1'b0;

		start_test("valid");
		for (int i = 0; i < 5; i++)
			run_one(0, types[i], model_exp, 0, 0, (i == 3) ? model_exp : 0);
		end_test();

		start_test("checksum");
		repeat (3) run_one(1, "0", model_exp, 0, 0, 0);
		run_one(0, "0", model_exp, 0, 0, 0);	// counter must not have moved
		end_test();

		start_test("header");
		for (int k = 2; k <= 4; k++) begin
			run_one(k, "A", model_exp, 0, 0, 0);
			run_one(0, "0", model_exp, 0, 0, 0);
		end
		end_test();

		start_test("missing");
		repeat (3) begin
			run_one(5, "0", model_exp, 0, 0, 0);
			run_one(0, "0", model_exp, 0, 0, 0);
		end
		end_test();

		start_test("sequence");
		run_one(0, "0", model_exp + 1 + rand_bits(3), 0, 0, 0);
		run_one(0, "0", model_exp - 1, 0, 0, 0);
		run_one(0, "0", model_exp - 1, 1, 0, 0);	// PossDup lets it through
		run_one(0, "4", model_exp, 0, 0, model_exp + 1 + rand_bits(4));
		run_one(0, "4", model_exp, 0, 1, model_exp + 1 + rand_bits(4));
		run_one(0, "4", model_exp - 1, 0, 0, model_exp + 5);
		run_one(0, "0", model_exp, 0, 0, 0);
		end_test();

		start_test("mix");
		repeat (60) begin
			kind = rand_bits(3) % 6;
			mt = types[rand_bits(3) % 5];
			seq = model_exp + rand_bits(2) - 1;	// around the expected number
			build_msg(kind, mt, seq, rand_bits(2) == 0, (mt == "4") && rand_bits(1),
				(mt == "4") ? seq + rand_bits(3) : 0);
			send_msg();
		end
		wait_verdicts();
		end_test();

		$display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
			n_tests, n_checks, n_errors, UUT.u_processor.u_props.fail_count);
		if (n_errors == 0 && UUT.u_processor.u_props.fail_count == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// ==== compile.f ====
fix_pkg.sv
fix_tag_parser.sv
fix_checksum.sv
fix_msg_processor.sv
fix_seq_tracker.sv
fix_rx_top.sv
fix_rx_props.sv
tb_fix_rx.sv

// ==== Bender.yml ====
package:
  name: fix_rx

sources:
  - fix_pkg.sv
  - fix_tag_parser.sv
  - fix_checksum.sv
  - fix_msg_processor.sv
  - fix_seq_tracker.sv
  - fix_rx_top.sv
  - target: test
    files:
      - fix_rx_props.sv
      - tb_fix_rx.sv
